//--- verilog/daq_pkg.sv
package daq_pkg;

    // ==============================
    // Sizes and timing
    // ==============================
    localparam int NUM_CHANNELS     = 8;
    localparam int CHANNEL_WIDTH    = 3;
    localparam int ADC_WIDTH        = 12;
    localparam int SAMPLE_WIDTH     = 16;
    // Kept small so the FIFO fills under a fast ADC
    localparam int FIFO_DEPTH       = 16;
    localparam int FIFO_COUNT_WIDTH = 5;
    localparam int SETTLE_CYCLES    = 8;
    localparam int ADDR_WIDTH       = 16;
    localparam int DATA_WIDTH       = 32;

    // Register reset values
    localparam logic CTRL_RESET = 1'b1;
    localparam logic [NUM_CHANNELS-1:0] CHAN_MASK_RESET = '1;

    // ==============================
    // Encodings
    // ==============================
    typedef enum logic [7:0] {
        SPI_OP_WRITE = 8'h02
    } spi_opcode_t;

    // Index is address bits 7 to 2
    typedef enum logic [5:0] {
        REG_CTRL      = 6'd0,
        REG_CHAN_MASK = 6'd1
    } cfg_reg_t;

    typedef enum logic [2:0] {
        SPI_CMD,
        SPI_ADDR_HIGH,
        SPI_ADDR_LOW,
        SPI_DATA_BYTE0,
        SPI_DATA_BYTE1,
        SPI_DATA_BYTE2,
        SPI_DATA_BYTE3,
        SPI_DONE
    } spi_state_t;

    typedef enum logic [2:0] {
        IDLE,
        SELECT_CHANNEL,
        START_CONVERSION,
        WAIT_CONVERSION,
        CAPTURE_DATA
    } adc_state_t;

    // Sample word, MSB first
    typedef struct packed {
        logic                     reserved;
        logic [CHANNEL_WIDTH-1:0] channel;
        logic [ADC_WIDTH-1:0]     data;
    } sample_t;

endpackage

//--- verilog/cfg_wr_if.sv
`timescale 1ns/1ns

// Register write request, SPI clock domain to system clock domain
interface cfg_wr_if;
    import daq_pkg::*;

    logic                  req;
    logic                  ack;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] data;

    // addr and data stay stable from req rise until ack is seen
    modport spi_side (
        output req,
        output addr,
        output data,
        input  ack
    );

    modport clk_side (
        input  req,
        input  addr,
        input  data,
        output ack
    );

endinterface

//--- verilog/spi_cfg_slave.sv
`timescale 1ns/1ns

module spi_cfg_slave (
    input  logic       rst_n,
    input  logic       spi_sclk,
    input  logic       spi_cs_n,
    input  logic       spi_mosi,
    cfg_wr_if.spi_side wr
);
    import daq_pkg::*;

    spi_state_t            state;
    logic [2:0]            bit_cnt;
    logic [6:0]            shift_q;
    logic [7:0]            byte_in;
    spi_opcode_t           opcode_q;
    logic [ADDR_WIDTH-1:0] addr_q;
    // Upper three data bytes, the last one comes straight from the shifter
    logic [DATA_WIDTH-9:0] data_q;
    logic                  ack_meta;
    logic                  ack_sync;
    logic                  byte_done;
    logic                  launch;

    assign byte_in   = {shift_q, spi_mosi};
    assign byte_done = !spi_cs_n && (bit_cnt == 3'd7);

    // Fire on bit 56, only after the previous handshake has closed
    assign launch = byte_done && (state == SPI_DATA_BYTE3) &&
                    (opcode_q == SPI_OP_WRITE) && !wr.req && !ack_sync;

    // ==============================
    // Ack synchronizer
    // ==============================
    always_ff @(posedge spi_sclk or negedge rst_n) begin
        if (!rst_n) begin
            ack_meta <= 1'b0;
            ack_sync <= 1'b0;
        end else begin
            ack_meta <= wr.ack;
            ack_sync <= ack_meta;
        end
    end

    // ==============================
    // Frame FSM
    // ==============================
    always_ff @(posedge spi_sclk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= SPI_CMD;
            bit_cnt <= '0;
        end else if (spi_cs_n) begin
            state   <= SPI_CMD;
            bit_cnt <= '0;
        end else if (state != SPI_DONE) begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) begin
                case (state)
                    SPI_CMD:        state <= SPI_ADDR_HIGH;
                    SPI_ADDR_HIGH:  state <= SPI_ADDR_LOW;
                    SPI_ADDR_LOW:   state <= SPI_DATA_BYTE0;
                    SPI_DATA_BYTE0: state <= SPI_DATA_BYTE1;
                    SPI_DATA_BYTE1: state <= SPI_DATA_BYTE2;
                    SPI_DATA_BYTE2: state <= SPI_DATA_BYTE3;
                    default:        state <= SPI_DONE;
                endcase
            end
        end
    end

    // Request stays up until ack comes back, even across chip select
    always_ff @(posedge spi_sclk or negedge rst_n) begin
        if (!rst_n) begin
            wr.req <= 1'b0;
        end else if (launch) begin
            wr.req <= 1'b1;
        end else if (ack_sync) begin
            wr.req <= 1'b0;
        end
    end

    // Byte assembly
    always_ff @(posedge spi_sclk) begin
        shift_q <= byte_in[6:0];
        if (byte_done) begin
            case (state)
                SPI_CMD:        opcode_q      <= spi_opcode_t'(byte_in);
                SPI_ADDR_HIGH:  addr_q[15:8]  <= byte_in;
                SPI_ADDR_LOW:   addr_q[7:0]   <= byte_in;
                SPI_DATA_BYTE0: data_q[23:16] <= byte_in;
                SPI_DATA_BYTE1: data_q[15:8]  <= byte_in;
                SPI_DATA_BYTE2: data_q[7:0]   <= byte_in;
                default: ;
            endcase
        end
        if (launch) begin
            wr.addr <= addr_q;
            wr.data <= {data_q, byte_in};
        end
    end

endmodule

//--- verilog/cfg_cdc_regs.sv
`timescale 1ns/1ns

module cfg_cdc_regs (
    input  logic                             clk,
    input  logic                             rst_n,
    cfg_wr_if.clk_side                       wr,
    output logic                             scan_enable,
    output logic [daq_pkg::NUM_CHANNELS-1:0] channel_mask
);
    import daq_pkg::*;

    logic                    req_meta;
    logic                    req_sync;
    logic                    req_prev;
    logic                    req_rise;
    logic                    wr_pend;
    cfg_reg_t                idx_q;
    logic [NUM_CHANNELS-1:0] data_q;

    // ==============================
    // Request synchronizer
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_meta <= 1'b0;
            req_sync <= 1'b0;
            req_prev <= 1'b0;
            wr_pend  <= 1'b0;
        end else begin
            req_meta <= wr.req;
            req_sync <= req_meta;
            req_prev <= req_sync;
            wr_pend  <= req_rise;
        end
    end

    assign req_rise = req_sync && !req_prev;

    // Ack is the synchronized request level
    assign wr.ack = req_sync;

    // Address and data are stable while req is high
    always_ff @(posedge clk) begin
        if (req_rise) begin
            idx_q  <= cfg_reg_t'(wr.addr[7:2]);
            data_q <= wr.data[NUM_CHANNELS-1:0];
        end
    end

    // ==============================
    // Configuration registers
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scan_enable  <= CTRL_RESET;
            channel_mask <= CHAN_MASK_RESET;
        end else if (wr_pend) begin
            case (idx_q)
                REG_CTRL:      scan_enable  <= data_q[0];
                REG_CHAN_MASK: channel_mask <= data_q;
                // Unused indices are dropped
                default: ;
            endcase
        end
    end

endmodule

//--- verilog/adc_sequencer.sv
`timescale 1ns/1ns

module adc_sequencer (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              scan_enable,
    input  logic [daq_pkg::NUM_CHANNELS-1:0]  channel_mask,
    input  logic                              fifo_full,
    input  logic                              adc_busy,
    input  logic                              adc_conv_done,
    input  logic [daq_pkg::ADC_WIDTH-1:0]     adc_data,
    output logic                              adc_start_conv,
    output logic [daq_pkg::CHANNEL_WIDTH-1:0] adc_channel_sel,
    output daq_pkg::sample_t                  sample_wdata,
    output logic                              sample_wr_en
);
    import daq_pkg::*;

    adc_state_t                           state;
    logic [$clog2(SETTLE_CYCLES+1)-1:0]   settle_cnt;
    logic [CHANNEL_WIDTH-1:0]             last_q;
    logic [CHANNEL_WIDTH-1:0]             next_chan;
    logic                                 found;
    logic                                 start_ok;
    logic [ADC_WIDTH-1:0]                 data_q;

    // ==============================
    // Round-robin pick
    // ==============================
    // First set mask bit after the last served channel, wrapping
    always_comb begin
        next_chan = last_q;
        found     = 1'b0;
        for (int i = 1; i <= NUM_CHANNELS; i++) begin
            if (!found && channel_mask[CHANNEL_WIDTH'((int'(last_q) + i) % NUM_CHANNELS)]) begin
                next_chan = CHANNEL_WIDTH'((int'(last_q) + i) % NUM_CHANNELS);
                found     = 1'b1;
            end
        end
    end

    // One sample in flight at most, so a non-full FIFO always has room
    assign start_ok = scan_enable && (|channel_mask) && !adc_busy && !fifo_full;

    // ==============================
    // Conversion FSM
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state           <= IDLE;
            settle_cnt      <= '0;
            adc_channel_sel <= '0;
            // Makes channel 0 the first pick
            last_q          <= CHANNEL_WIDTH'(NUM_CHANNELS - 1);
        end else begin
            case (state)
                IDLE: begin
                    if (start_ok) begin
                        adc_channel_sel <= next_chan;
                        last_q          <= next_chan;
                        settle_cnt      <= '0;
                        state           <= SELECT_CHANNEL;
                    end
                end
                SELECT_CHANNEL: begin
                    if (settle_cnt == SETTLE_CYCLES) begin
                        state <= START_CONVERSION;
                    end else begin
                        settle_cnt <= settle_cnt + 1'b1;
                    end
                end
                START_CONVERSION: state <= WAIT_CONVERSION;
                WAIT_CONVERSION: begin
                    if (adc_conv_done) begin
                        state <= CAPTURE_DATA;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Result is taken with done
    always_ff @(posedge clk) begin
        if (state == WAIT_CONVERSION && adc_conv_done) begin
            data_q <= adc_data;
        end
    end

    assign adc_start_conv = (state == START_CONVERSION);
    assign sample_wr_en   = (state == CAPTURE_DATA);

    always_comb begin
        sample_wdata.reserved = 1'b0;
        sample_wdata.channel  = adc_channel_sel;
        sample_wdata.data     = data_q;
    end

endmodule

//--- verilog/sample_fifo.sv
`timescale 1ns/1ns

module sample_fifo (
    input  logic             clk,
    input  logic             rst_n,
    input  daq_pkg::sample_t wr_data,
    input  logic             wr_en,
    output logic             full,
    output daq_pkg::sample_t rd_data,
    input  logic             rd_en,
    output logic             empty
);
    import daq_pkg::*;

    sample_t                       mem [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
    logic [FIFO_COUNT_WIDTH-1:0]   count;
    logic                          do_wr;
    logic                          do_rd;

    assign full  = (count == FIFO_COUNT_WIDTH'(FIFO_DEPTH));
    assign empty = (count == '0);
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    // Head of queue is visible without a read
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Pointers wrap at the power-of-two depth
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- verilog/serial_tx.sv
`timescale 1ns/1ns

module serial_tx (
    input  logic             clk,
    input  logic             rst_n,
    input  daq_pkg::sample_t rd_data,
    output logic             rd_en,
    input  logic             empty,
    output logic             serial_data,
    output logic             serial_valid
);
    import daq_pkg::*;

    logic                            busy;
    logic [$clog2(SAMPLE_WIDTH)-1:0] bit_cnt;
    logic [SAMPLE_WIDTH-1:0]         shift_q;

    // Pop the head as it is loaded
    assign rd_en = !busy && !empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            bit_cnt <= '0;
        end else if (rd_en) begin
            busy    <= 1'b1;
            bit_cnt <= '0;
        end else if (busy) begin
            bit_cnt <= bit_cnt + 1'b1;
            // Last bit, then one idle cycle
            if (bit_cnt == SAMPLE_WIDTH - 1) busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) shift_q <= rd_data;
        else if (busy) shift_q <= {shift_q[SAMPLE_WIDTH-2:0], 1'b0};
    end

    assign serial_data  = shift_q[SAMPLE_WIDTH-1];
    assign serial_valid = busy;

endmodule

//--- verilog/daq_top.sv
`timescale 1ns/1ns

module daq_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              spi_sclk,
    input  logic                              spi_cs_n,
    input  logic                              spi_mosi,
    input  logic                              adc_busy,
    input  logic                              adc_conv_done,
    input  logic [daq_pkg::ADC_WIDTH-1:0]     adc_data,
    output logic                              adc_start_conv,
    output logic [daq_pkg::CHANNEL_WIDTH-1:0] adc_channel_sel,
    output logic                              serial_data,
    output logic                              serial_valid,
    output logic                              fifo_full_irq
);
    import daq_pkg::*;

    logic                    scan_enable;
    logic [NUM_CHANNELS-1:0] channel_mask;
    sample_t                 sample_wdata;
    logic                    sample_wr_en;
    sample_t                 fifo_rd_data;
    logic                    fifo_rd_en;
    logic                    fifo_full;
    logic                    fifo_empty;

    // ==============================
    // Configuration path
    // ==============================
    cfg_wr_if cfg_wr ();

    spi_cfg_slave u_spi_cfg_slave (
        .rst_n    (rst_n),
        .spi_sclk (spi_sclk),
        .spi_cs_n (spi_cs_n),
        .spi_mosi (spi_mosi),
        .wr       (cfg_wr.spi_side)
    );

    cfg_cdc_regs u_cfg_cdc_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr           (cfg_wr.clk_side),
        .scan_enable  (scan_enable),
        .channel_mask (channel_mask)
    );

    // ==============================
    // Sample path
    // ==============================
    adc_sequencer u_adc_sequencer (
        .clk             (clk),
        .rst_n           (rst_n),
        .scan_enable     (scan_enable),
        .channel_mask    (channel_mask),
        .fifo_full       (fifo_full),
        .adc_busy        (adc_busy),
        .adc_conv_done   (adc_conv_done),
        .adc_data        (adc_data),
        .adc_start_conv  (adc_start_conv),
        .adc_channel_sel (adc_channel_sel),
        .sample_wdata    (sample_wdata),
        .sample_wr_en    (sample_wr_en)
    );

    sample_fifo u_sample_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_data (sample_wdata),
        .wr_en   (sample_wr_en),
        .full    (fifo_full),
        .rd_data (fifo_rd_data),
        .rd_en   (fifo_rd_en),
        .empty   (fifo_empty)
    );

    serial_tx u_serial_tx (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd_data      (fifo_rd_data),
        .rd_en        (fifo_rd_en),
        .empty        (fifo_empty),
        .serial_data  (serial_data),
        .serial_valid (serial_valid)
    );

    // Interrupt is the FIFO full flag
    assign fifo_full_irq = fifo_full;

endmodule

//--- include/daq_tb_tasks.svh
`ifndef DAQ_TB_TASKS_SVH
`define DAQ_TB_TASKS_SVH

// ==============================
// SPI master
// ==============================
// One 56-bit frame, MSB first, data changes on falling spi_sclk
task automatic send_frame(input logic [7:0] op, input logic [15:0] addr,
                          input logic [31:0] data);
    logic [55:0] frame;
    frame = {op, addr, data};
    @(negedge spi_sclk);
    spi_cs_n = 1'b0;
    for (int i = 55; i >= 0; i--) begin
        spi_mosi = frame[i];
        @(negedge spi_sclk);
    end
    spi_cs_n = 1'b1;
    spi_mosi = 1'b0;
endtask

// ==============================
// ADC responder
// ==============================
// Answers one start pulse with a done pulse and a random result
task automatic adc_respond();
    int          delay;
    int          hold;
    logic [2:0]  chan;
    logic [11:0] value;
    @(negedge clk);
    if (rst_n && adc_start_conv) begin
        chan  = adc_channel_sel;
        delay = fast_adc ? 1 : 1 + int'($unsigned($random(seed)) % 6);
        value = 12'($random(seed));
        repeat (delay) @(posedge clk);
        #1;
        adc_conv_done = 1'b1;
        adc_data      = value;
        model_q.push_back({1'b0, chan, value});
        done_count++;
        @(posedge clk);
        #1;
        adc_conv_done = 1'b0;
        // Occasional busy, keeps the sequencer in IDLE for a while
        if (busy_random && (($random(seed) & 3) == 0)) begin
            hold     = 1 + int'($unsigned($random(seed)) % 4);
            adc_busy = 1'b1;
            repeat (hold) @(posedge clk);
            #1;
            adc_busy = 1'b0;
        end
    end
endtask

// ==============================
// Reference model
// ==============================
// First set mask bit after the last served channel, with wrap
function automatic logic [2:0] next_channel(input logic [2:0] last, input logic [7:0] mask);
    logic [2:0] cand;
    for (int i = 1; i <= 8; i++) begin
        cand = last + 3'(i);
        if (mask[cand]) begin
            return cand;
        end
    end
    return last;
endfunction

// Oldest recorded conversion against a received word
task automatic compare_word(input logic [15:0] word);
    check_value(model_q.size() > 0, 1, "conversion pending for serial word");
    if (model_q.size() > 0) begin
        check_value(word, model_q.pop_front(), "serial word");
    end
endtask

`endif

//--- dv/daq_tb.sv
`timescale 1ns/1ns

module daq_tb;
    import daq_pkg::*;

    logic                     clk;
    logic                     rst_n;
    logic                     spi_sclk;
    logic                     spi_cs_n;
    logic                     spi_mosi;
    logic                     adc_busy;
    logic                     adc_conv_done;
    logic [ADC_WIDTH-1:0]     adc_data;
    logic                     adc_start_conv;
    logic [CHANNEL_WIDTH-1:0] adc_channel_sel;
    logic                     serial_data;
    logic                     serial_valid;
    logic                     fifo_full_irq;

    integer      seed = 46;
    int          errors;
    int          checks;
    int          err_mark;
    event        timeout_ev;
    // Model and monitor state
    logic [15:0] model_q[$];
    logic [7:0]  model_mask;
    logic [2:0]  last_chan;
    logic [2:0]  prev_sel;
    logic        rr_check;
    logic        fast_adc;
    logic        busy_random;
    int          start_count;
    int          done_count;
    int          words_rx;
    int          hold_cnt;
    int          rx_bits;
    logic [15:0] rx_word;
    logic [7:0]  mask;

    daq_top DUT (.*);

    always #4 clk = ~clk;
    always #12 spi_sclk = ~spi_sclk;

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string msg);
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] %0t ns: %s, got %0h, expected %0h", $time, msg, got, exp);
            errors++;
        end
    endtask

    `include "daq_tb_tasks.svh"

    // The test sequence parks here and the watchdog ends the run
    task automatic abort_on_timeout(input string what);
        $display("Timed out at %0t ns while waiting for %s", $time, what);
        -> timeout_ev;
        forever @(posedge clk);
    endtask

    task automatic report_test(input int num, input string name);
        $display("Test %0d %s: %s", num, name, (errors == err_mark) ? "ok" : "errors");
        err_mark = errors;
    endtask

    // ==============================
    // Wait loops
    // ==============================
    task automatic wait_starts(input int target, input int limit);
        int n;
        n = 0;
        while (start_count < target && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (start_count < target) begin
            abort_on_timeout("ADC conversions");
        end
    endtask

    task automatic wait_words(input int target, input int limit);
        int n;
        n = 0;
        while (words_rx < target && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (words_rx < target) begin
            abort_on_timeout("serial words");
        end
    endtask

    task automatic wait_full(input int limit);
        int n;
        n = 0;
        while (!fifo_full_irq && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!fifo_full_irq) begin
            abort_on_timeout("a full FIFO");
        end
    endtask

    task automatic wait_drained(input int limit);
        int n;
        n = 0;
        while ((words_rx < done_count || rx_bits != 0) && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (words_rx < done_count || rx_bits != 0) begin
            abort_on_timeout("the serial output to drain");
        end
    endtask

    // ==============================
    // Monitors
    // ==============================
    // Settle time and channel order at each start pulse
    always @(negedge clk) begin
        if (rst_n) begin
            if (adc_channel_sel != prev_sel) begin
                hold_cnt = 0;
            end else begin
                hold_cnt++;
            end
            prev_sel = adc_channel_sel;
            if (adc_start_conv) begin
                check_value(hold_cnt >= SETTLE_CYCLES, 1, "channel select settle time");
                if (rr_check) begin
                    check_value(adc_channel_sel, next_channel(last_chan, model_mask),
                                "round-robin channel");
                end
                last_chan = adc_channel_sel;
                start_count++;
            end
        end
    end

    // Serial receiver shifting in MSB first
    always @(negedge clk) begin
        if (rst_n && serial_valid) begin
            rx_word = {rx_word[14:0], serial_data};
            rx_bits++;
        end else if (rx_bits != 0) begin
            check_value(rx_bits, 16, "serial_valid run length");
            compare_word(rx_word);
            words_rx++;
            rx_bits = 0;
        end
    end

    always begin
        adc_respond();
    end

    // Ends the run once a wait has timed out
    initial begin
        @(timeout_ev);
        $display("Checks failed");
        $finish;
    end

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        clk           = 1'b0;
        spi_sclk      = 1'b0;
        rst_n         = 1'b0;
        spi_cs_n      = 1'b1;
        spi_mosi      = 1'b0;
        adc_busy      = 1'b0;
        adc_conv_done = 1'b0;
        adc_data      = '0;
        errors        = 0;
        checks        = 0;
        err_mark      = 0;
        model_mask    = 8'hff;
        last_chan     = 3'd7;
        prev_sel      = 3'd0;
        rr_check      = 1'b1;
        fast_adc      = 1'b0;
        busy_random   = 1'b1;
        start_count   = 0;
        done_count    = 0;
        words_rx      = 0;
        hold_cnt      = 0;
        rx_bits       = 0;
        rx_word       = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        @(negedge clk);
        check_value(adc_start_conv, 0, "adc_start_conv after reset");
        check_value(serial_valid, 0, "serial_valid after reset");
        check_value(fifo_full_irq, 0, "fifo_full_irq after reset");
        check_value(adc_channel_sel, 0, "adc_channel_sel after reset");
        wait_starts(16, 2000);
        report_test(1, "reset and full round-robin scan");

        wait_words(16, 2000);
        report_test(2, "serial words against model");

        // Old mask may still be in flight until the wait is over
        rr_check = 1'b0;
        mask = 8'h00;
        while (mask == 8'h00 || mask == 8'hff) begin
            mask = 8'($random(seed));
        end
        send_frame(SPI_OP_WRITE, {8'h00, REG_CHAN_MASK, 2'b00}, {24'h0, mask});
        model_mask = mask;
        repeat (60) @(posedge clk);
        rr_check = 1'b1;
        wait_starts(start_count + 12, 2000);
        report_test(3, "channel mask write");

        send_frame(8'h03, {8'h00, REG_CTRL, 2'b00}, 32'h0);
        repeat (60) @(posedge clk);
        wait_starts(start_count + 2, 500);
        send_frame(SPI_OP_WRITE, {8'h00, 6'd5, 2'b00}, 32'h0);
        repeat (60) @(posedge clk);
        wait_starts(start_count + 2, 500);
        send_frame(SPI_OP_WRITE, {8'h00, REG_CTRL, 2'b00}, 32'h0);
        repeat (60) @(posedge clk);
        mask = 8'(start_count);
        repeat (200) @(posedge clk);
        check_value(8'(start_count), mask, "conversions while scan is disabled");
        send_frame(SPI_OP_WRITE, {8'h00, REG_CTRL, 2'b00}, 32'h1);
        wait_starts(start_count + 1, 400);
        report_test(4, "ignored frames and scan enable");

        busy_random = 1'b0;
        fast_adc    = 1'b1;
        wait_full(4000);
        send_frame(SPI_OP_WRITE, {8'h00, REG_CTRL, 2'b00}, 32'h0);
        repeat (60) @(posedge clk);
        wait_drained(1000);
        repeat (40) @(posedge clk);
        check_value(words_rx, done_count, "serial words against conversions");
        check_value(model_q.size(), 0, "conversions left without a serial word");
        report_test(5, "FIFO full back-pressure");

        $display("Checks run: %0d, errors: %0d, words received: %0d", checks, errors, words_rx);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+include
verilog/daq_pkg.sv
verilog/cfg_wr_if.sv
verilog/spi_cfg_slave.sv
verilog/cfg_cdc_regs.sv
verilog/adc_sequencer.sv
verilog/sample_fifo.sv
verilog/serial_tx.sv
verilog/daq_top.sv
dv/daq_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, then search the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module daq_tb -f sources.f -o daq_sim \
    && ./obj_dir/daq_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Checks failed" sim.log && { echo "Result: FAIL"; exit 1; } || { echo "Result: PASS"; exit 0; }
